/* include/decode_macros.svh */
/*
  Shared widths and major opcode values for the decode stage
  Included by the package, the expander, the sub-decoders and the top level
*/
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Instruction word and immediate width
`define DEC_XLEN 32
// Register address width, 32 integer registers
`define DEC_REG_AW 5

// Major opcodes, bits [6:0] of an uncompressed word
`define DEC_OPC_OP 7'b0110011
`define DEC_OPC_OP_IMM 7'b0010011
`define DEC_OPC_LUI 7'b0110111
`define DEC_OPC_LOAD 7'b0000011
`define DEC_OPC_STORE 7'b0100011
`define DEC_OPC_AMO 7'b0101111

`endif

/* source/decode_pkg.sv */
/*
  Decode types: instruction format union, execution unit enum,
  per-unit operation codes, the control record and its idle value
*/
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

  ////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [`DEC_REG_AW-1:0] rs2;
    logic [`DEC_REG_AW-1:0] rs1;
    logic [2:0] funct3;
    logic [`DEC_REG_AW-1:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [`DEC_REG_AW-1:0] rs1;
    logic [2:0] funct3;
    logic [`DEC_REG_AW-1:0] rd;
    logic [6:0] opcode;
  } i_type_t;

  // One word, two readings; S and U immediates are pieced together from the R view
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_fmt_u;

  ////////////////////////////////////////
  // Units and operations
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    NONE = 3'd0,
    ALU = 3'd1,
    LSU = 3'd2,
    MULDIV = 3'd3,
    ATOMIC = 3'd4
  } exec_unit_e;

  // The same code means different things in different units
  typedef logic [3:0] dec_op_e;

  // ALU operations
  localparam dec_op_e ALU_ADD = 4'd0;
  localparam dec_op_e ALU_SUB = 4'd1;
  localparam dec_op_e ALU_SLL = 4'd2;
  localparam dec_op_e ALU_SLT = 4'd3;
  localparam dec_op_e ALU_SLTU = 4'd4;
  localparam dec_op_e ALU_XOR = 4'd5;
  localparam dec_op_e ALU_SRL = 4'd6;
  localparam dec_op_e ALU_SRA = 4'd7;
  localparam dec_op_e ALU_OR = 4'd8;
  localparam dec_op_e ALU_AND = 4'd9;
  localparam dec_op_e ALU_LUI = 4'd10;

  // Load/store operations
  localparam dec_op_e LSU_LW = 4'd0;
  localparam dec_op_e LSU_SW = 4'd1;

  // Multiply/divide codes follow funct3, so mul is 0 and remu is 7
  localparam dec_op_e MD_MUL = 4'd0;
  localparam dec_op_e MD_REMU = 4'd7;

  // Atomic operations
  localparam dec_op_e AMO_LR = 4'd0;
  localparam dec_op_e AMO_SC = 4'd1;
  localparam dec_op_e AMO_SWAP = 4'd2;
  localparam dec_op_e AMO_ADD = 4'd3;
  localparam dec_op_e AMO_XOR = 4'd4;
  localparam dec_op_e AMO_AND = 4'd5;
  localparam dec_op_e AMO_OR = 4'd6;
  localparam dec_op_e AMO_MIN = 4'd7;
  localparam dec_op_e AMO_MAX = 4'd8;

  ////////////////////////////////////////
  // Control record
  ////////////////////////////////////////

  typedef struct packed {
    logic illegal_insn;
    exec_unit_e unit;
    dec_op_e op;
    logic rd_we;
    logic [`DEC_REG_AW-1:0] rd;
    logic [`DEC_REG_AW-1:0] rs1;
    logic [`DEC_REG_AW-1:0] rs2;
    logic use_imm;
    logic [`DEC_XLEN-1:0] imm;
  } decoder_ctrl_t;

  // Idle record; a decoder with no match drives exactly this
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    illegal_insn: 1'b1,
    unit: NONE,
    op: 4'd0,
    rd_we: 1'b0,
    rd: '0,
    rs1: '0,
    rs2: '0,
    use_imm: 1'b0,
    imm: '0
  };

endpackage

`default_nettype wire

/* source/instr_fetch_if.sv */
/*
  Expanded instruction bundle between the compressed expander,
  the three sub-decoders and the merging decoder
*/
`timescale 1ns/10ps
`default_nettype none

interface instr_fetch_if;

  logic valid;
  // Always an uncompressed encoding, low two bits at 11
  decode_pkg::instr_fmt_u instr;
  // Compressed input that the expander does not support
  logic c_illegal;
  logic was_compressed;

  modport expander (output valid, output instr, output c_illegal, output was_compressed);

  // Sub-decoders only look at the word itself
  modport decoder (input instr);

  modport merge (input valid, input c_illegal, input was_compressed);

endinterface

`default_nettype wire

/* source/compressed_expander.sv */
/*
  Compressed expander: rebuilds C.ADDI, C.LI, C.LUI, C.MV, C.ADD,
  C.LW and C.SW as 32-bit words, flags every other compressed form
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module compressed_expander (
  input logic [`DEC_XLEN-1:0] instr_rdata,
  instr_fetch_if.expander fetch,
  input logic instr_valid
);

  // Compressed encoding sits in the lower half
  logic [15:0] c;
  logic is_compressed;
  logic [`DEC_XLEN-1:0] expanded;
  logic illegal;

  // Full register fields in CI and CR forms
  logic [`DEC_REG_AW-1:0] rd_full;
  logic [`DEC_REG_AW-1:0] rs2_full;
  // Three-bit register fields map onto x8 to x15
  logic [`DEC_REG_AW-1:0] rdrs2_p;
  logic [`DEC_REG_AW-1:0] rs1_p;
  // Sign-extended 6-bit CI immediate
  logic [11:0] imm6_sx;
  // Word offset for C.LW and C.SW, scaled by four
  logic [11:0] mem_off;

  assign c = instr_rdata[15:0];
  assign is_compressed = (instr_rdata[1:0] != 2'b11);

  assign rd_full = c[11:7];
  assign rs2_full = c[6:2];
  assign rdrs2_p = {2'b01, c[4:2]};
  assign rs1_p = {2'b01, c[9:7]};
  assign imm6_sx = {{6{c[12]}}, c[12], c[6:2]};
  assign mem_off = {5'b0, c[5], c[12:10], c[6], 2'b00};

  always_comb begin
    // Unsupported forms emit a word that still ends in 11
    expanded = {30'b0, 2'b11};
    illegal = 1'b0;
    if (!is_compressed) begin
      expanded = instr_rdata;
    end else begin
      illegal = 1'b1;
      // Quadrant and funct3 together select the form
      case ({c[1:0], c[15:13]})
        5'b01_000: begin
          // C.ADDI becomes addi rd, rd, imm
          expanded = {imm6_sx, rd_full, 3'b000, rd_full, `DEC_OPC_OP_IMM};
          illegal = 1'b0;
        end
        5'b01_010: begin
          // C.LI becomes addi rd, x0, imm
          expanded = {imm6_sx, 5'd0, 3'b000, rd_full, `DEC_OPC_OP_IMM};
          illegal = 1'b0;
        end
        5'b01_011: begin
          // rd of x2 is C.ADDI16SP, and a zero immediate is reserved
          if (rd_full != 5'd0 && rd_full != 5'd2 && {c[12], c[6:2]} != 6'd0) begin
            expanded = {{14{c[12]}}, c[12], c[6:2], rd_full, `DEC_OPC_LUI};
            illegal = 1'b0;
          end
        end
        5'b10_100: begin
          // rs2 of x0 means C.JR, C.JALR or C.EBREAK, none supported
          if (rs2_full != 5'd0) begin
            if (!c[12]) begin
              // C.MV becomes add rd, x0, rs2
              expanded = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, `DEC_OPC_OP};
            end else begin
              // C.ADD becomes add rd, rd, rs2
              expanded = {7'b0, rs2_full, rd_full, 3'b000, rd_full, `DEC_OPC_OP};
            end
            illegal = 1'b0;
          end
        end
        5'b00_010: begin
          expanded = {mem_off, rs1_p, 3'b010, rdrs2_p, `DEC_OPC_LOAD};
          illegal = 1'b0;
        end
        5'b00_110: begin
          // Store immediate is split around the register fields
          expanded = {mem_off[11:5], rdrs2_p, rs1_p, 3'b010, mem_off[4:0], `DEC_OPC_STORE};
          illegal = 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  assign fetch.valid = instr_valid;
  assign fetch.instr = expanded;
  assign fetch.c_illegal = illegal;
  assign fetch.was_compressed = is_compressed;

endmodule

`default_nettype wire

/* source/decoder_i.sv */
/*
  Base integer sub-decoder: OP, OP-IMM, LUI, LW and SW
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decoder_i (
  instr_fetch_if.decoder fetch,
  output decode_pkg::decoder_ctrl_t ctrl
);

  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [6:0] imm_hi;
  logic op_legal;
  logic op_imm_legal;
  logic is_shift;

  // funct3 to ALU operation; alt picks sub over add and sra over srl
  function automatic decode_pkg::dec_op_e alu_op(input logic [2:0] f3, input logic alt);
    decode_pkg::dec_op_e op;
    case (f3)
      3'b000: op = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'b001: op = decode_pkg::ALU_SLL;
      3'b010: op = decode_pkg::ALU_SLT;
      3'b011: op = decode_pkg::ALU_SLTU;
      3'b100: op = decode_pkg::ALU_XOR;
      3'b101: op = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'b110: op = decode_pkg::ALU_OR;
      default: op = decode_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign funct7 = fetch.instr.r.funct7;
  assign funct3 = fetch.instr.r.funct3;
  // Upper immediate bits hold the shift type for OP-IMM shifts
  assign imm_hi = fetch.instr.i.imm12[11:5];
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  // The alternate funct7 only exists for sub and sra
  assign op_legal = (funct7 == 7'b0) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    op_imm_legal = 1'b1;
    if (funct3 == 3'b001) begin
      op_imm_legal = (imm_hi == 7'b0);
    end else if (funct3 == 3'b101) begin
      op_imm_legal = (imm_hi == 7'b0) || (imm_hi == 7'b0100000);
    end
  end

  always_comb begin
    ctrl = decode_pkg::DECODER_CTRL_ILLEGAL;
    case (fetch.instr.r.opcode)
      `DEC_OPC_OP: begin
        if (op_legal) begin
          ctrl.illegal_insn = 1'b0;
          ctrl.unit = decode_pkg::ALU;
          ctrl.op = alu_op(funct3, funct7[5]);
          ctrl.rd_we = 1'b1;
          ctrl.rd = fetch.instr.r.rd;
          ctrl.rs1 = fetch.instr.r.rs1;
          ctrl.rs2 = fetch.instr.r.rs2;
        end
      end
      `DEC_OPC_OP_IMM: begin
        if (op_imm_legal) begin
          ctrl.illegal_insn = 1'b0;
          ctrl.unit = decode_pkg::ALU;
          // Only srai may set bit 30; for addi it is just an immediate bit
          ctrl.op = alu_op(funct3, (funct3 == 3'b101) && imm_hi[5]);
          ctrl.rd_we = 1'b1;
          ctrl.rd = fetch.instr.i.rd;
          ctrl.rs1 = fetch.instr.i.rs1;
          ctrl.use_imm = 1'b1;
          // Shifts carry a zero-extended shift amount
          ctrl.imm = is_shift ? {27'b0, fetch.instr.i.imm12[4:0]} :
                                {{20{fetch.instr.i.imm12[11]}}, fetch.instr.i.imm12};
        end
      end
      `DEC_OPC_LUI: begin
        ctrl.illegal_insn = 1'b0;
        ctrl.unit = decode_pkg::ALU;
        ctrl.op = decode_pkg::ALU_LUI;
        ctrl.rd_we = 1'b1;
        ctrl.rd = fetch.instr.r.rd;
        ctrl.use_imm = 1'b1;
        ctrl.imm = {fetch.instr.r.funct7, fetch.instr.r.rs2, fetch.instr.r.rs1,
                    fetch.instr.r.funct3, 12'b0};
      end
      `DEC_OPC_LOAD: begin
        // Word loads only
        if (funct3 == 3'b010) begin
          ctrl.illegal_insn = 1'b0;
          ctrl.unit = decode_pkg::LSU;
          ctrl.op = decode_pkg::LSU_LW;
          ctrl.rd_we = 1'b1;
          ctrl.rd = fetch.instr.i.rd;
          ctrl.rs1 = fetch.instr.i.rs1;
          ctrl.use_imm = 1'b1;
          ctrl.imm = {{20{fetch.instr.i.imm12[11]}}, fetch.instr.i.imm12};
        end
      end
      `DEC_OPC_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl.illegal_insn = 1'b0;
          ctrl.unit = decode_pkg::LSU;
          ctrl.op = decode_pkg::LSU_SW;
          ctrl.rs1 = fetch.instr.r.rs1;
          ctrl.rs2 = fetch.instr.r.rs2;
          ctrl.use_imm = 1'b1;
          // S immediate sits in the funct7 and rd slots
          ctrl.imm = {{20{funct7[6]}}, funct7, fetch.instr.r.rd};
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/decoder_m.sv */
/*
  Multiply/divide sub-decoder for mul, mulh, mulhsu, mulhu,
  div, divu, rem and remu
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decoder_m (
  instr_fetch_if.decoder fetch,
  output decode_pkg::decoder_ctrl_t ctrl
);

  logic match;

  // Same major opcode as base OP, told apart by funct7
  assign match = (fetch.instr.r.opcode == `DEC_OPC_OP) &&
                 (fetch.instr.r.funct7 == 7'b0000001);

  always_comb begin
    ctrl = decode_pkg::DECODER_CTRL_ILLEGAL;
    if (match) begin
      ctrl.illegal_insn = 1'b0;
      ctrl.unit = decode_pkg::MULDIV;
      // Operation code is funct3 itself, MD_MUL up to MD_REMU
      ctrl.op = {1'b0, fetch.instr.i.funct3};
      ctrl.rd_we = 1'b1;
      ctrl.rd = fetch.instr.i.rd;
      ctrl.rs1 = fetch.instr.i.rs1;
      ctrl.rs2 = fetch.instr.r.rs2;
    end
  end

endmodule

`default_nettype wire

/* source/decoder_a.sv */
/*
  Atomic sub-decoder for word-sized LR, SC and AMO operations
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decoder_a (
  instr_fetch_if.decoder fetch,
  output decode_pkg::decoder_ctrl_t ctrl
);

  // funct5 is the top of funct7; aq and rl below it are ignored here
  logic [4:0] funct5;
  logic word_amo;
  logic supported;
  decode_pkg::dec_op_e amo_op;

  assign funct5 = fetch.instr.r.funct7[6:2];
  assign word_amo = (fetch.instr.i.opcode == `DEC_OPC_AMO) && (fetch.instr.i.funct3 == 3'b010);

  always_comb begin
    supported = 1'b1;
    amo_op = decode_pkg::AMO_LR;
    case (funct5)
      // LR has no second source, so rs2 must be zero
      5'b00010: supported = (fetch.instr.r.rs2 == 5'd0);
      5'b00011: amo_op = decode_pkg::AMO_SC;
      5'b00001: amo_op = decode_pkg::AMO_SWAP;
      5'b00000: amo_op = decode_pkg::AMO_ADD;
      5'b00100: amo_op = decode_pkg::AMO_XOR;
      5'b01100: amo_op = decode_pkg::AMO_AND;
      5'b01000: amo_op = decode_pkg::AMO_OR;
      5'b10000: amo_op = decode_pkg::AMO_MIN;
      5'b10100: amo_op = decode_pkg::AMO_MAX;
      default: supported = 1'b0;
    endcase
  end

  always_comb begin
    ctrl = decode_pkg::DECODER_CTRL_ILLEGAL;
    if (word_amo && supported) begin
      ctrl.illegal_insn = 1'b0;
      ctrl.unit = decode_pkg::ATOMIC;
      ctrl.op = amo_op;
      ctrl.rd_we = 1'b1;
      ctrl.rd = fetch.instr.i.rd;
      ctrl.rs1 = fetch.instr.i.rs1;
      ctrl.rs2 = fetch.instr.r.rs2;
    end
  end

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
/*
  Merging decoder: picks the matching sub-decoder record,
  falls back to the idle record and registers the result
*/
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input logic clk,
  input logic rst,
  instr_fetch_if.merge fetch,
  input decode_pkg::decoder_ctrl_t ctrl_i,
  input decode_pkg::decoder_ctrl_t ctrl_m,
  input decode_pkg::decoder_ctrl_t ctrl_a,
  output decode_pkg::decoder_ctrl_t dec_ctrl,
  output logic dec_valid,
  output logic dec_compressed
);

  decode_pkg::decoder_ctrl_t ctrl_sel;

  ////////////////////////////////////////
  // Record selection
  ////////////////////////////////////////

  // The sub-decoders never match the same word, so the order is arbitrary
  always_comb begin
    ctrl_sel = decode_pkg::DECODER_CTRL_ILLEGAL;
    // A rejected compressed form stays illegal whatever was emitted
    if (!fetch.c_illegal) begin
      if (!ctrl_i.illegal_insn) begin
        ctrl_sel = ctrl_i;
      end else if (!ctrl_m.illegal_insn) begin
        ctrl_sel = ctrl_m;
      end else if (!ctrl_a.illegal_insn) begin
        ctrl_sel = ctrl_a;
      end
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // One cycle of latency, one result per accepted word
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      dec_ctrl <= decode_pkg::DECODER_CTRL_ILLEGAL;
      dec_compressed <= 1'b0;
    end else begin
      dec_valid <= fetch.valid;
      if (fetch.valid) begin
        dec_ctrl <= ctrl_sel;
        dec_compressed <= fetch.was_compressed;
      end else begin
        // Between instructions the outputs rest at the idle value
        dec_ctrl <= decode_pkg::DECODER_CTRL_ILLEGAL;
        dec_compressed <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
/*
  Decode stage top: expander, sub-decoders and merging decoder
  with the registered control record spread onto plain ports
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input logic [`DEC_XLEN-1:0] instr_rdata,
  output logic dec_valid,
  output logic dec_illegal,
  output logic [2:0] dec_unit,
  output logic [3:0] dec_op,
  output logic dec_rd_we,
  output logic [`DEC_REG_AW-1:0] dec_rd,
  output logic [`DEC_REG_AW-1:0] dec_rs1,
  output logic [`DEC_REG_AW-1:0] dec_rs2,
  output logic dec_use_imm,
  output logic [`DEC_XLEN-1:0] dec_imm,
  output logic dec_compressed
);

  instr_fetch_if fetch_if ();

  decode_pkg::decoder_ctrl_t ctrl_i;
  decode_pkg::decoder_ctrl_t ctrl_m;
  decode_pkg::decoder_ctrl_t ctrl_a;
  decode_pkg::decoder_ctrl_t dec_ctrl;

  compressed_expander u_expander (
    .instr_rdata(instr_rdata),
    .fetch(fetch_if.expander),
    .instr_valid(instr_valid)
  );

  // Three sub-decoders look at the same expanded word in parallel
  decoder_i u_decoder_i (.fetch(fetch_if.decoder), .ctrl(ctrl_i));
  decoder_m u_decoder_m (.fetch(fetch_if.decoder), .ctrl(ctrl_m));
  decoder_a u_decoder_a (.fetch(fetch_if.decoder), .ctrl(ctrl_a));

  instr_decoder u_instr_decoder (
    .clk(clk),
    .rst(rst),
    .fetch(fetch_if.merge),
    .ctrl_i(ctrl_i),
    .ctrl_m(ctrl_m),
    .ctrl_a(ctrl_a),
    .dec_ctrl(dec_ctrl),
    .dec_valid(dec_valid),
    .dec_compressed(dec_compressed)
  );

  // Record fields out to the ports
  assign dec_illegal = dec_ctrl.illegal_insn;
  assign dec_unit = dec_ctrl.unit;
  assign dec_op = dec_ctrl.op;
  assign dec_rd_we = dec_ctrl.rd_we;
  assign dec_rd = dec_ctrl.rd;
  assign dec_rs1 = dec_ctrl.rs1;
  assign dec_rs2 = dec_ctrl.rs2;
  assign dec_use_imm = dec_ctrl.use_imm;
  assign dec_imm = dec_ctrl.imm;

endmodule

`default_nettype wire

/* verif/decode_checker.sv */
/*
  Checker for the decode stage: queue of expected results,
  output comparison, idle-value rule, valid timing, error counts
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decode_checker (
  input logic clk,
  input logic rst,
  // Input side of the DUT plus the expected row for that word
  input logic instr_valid,
  input logic [`DEC_XLEN-1:0] instr_rdata,
  input logic exp_full,
  input logic [57:0] exp_row,
  // DUT outputs
  input logic dec_valid,
  input logic dec_illegal,
  input logic [2:0] dec_unit,
  input logic [3:0] dec_op,
  input logic dec_rd_we,
  input logic [`DEC_REG_AW-1:0] dec_rd,
  input logic [`DEC_REG_AW-1:0] dec_rs1,
  input logic [`DEC_REG_AW-1:0] dec_rs2,
  input logic dec_use_imm,
  input logic [`DEC_XLEN-1:0] dec_imm,
  input logic dec_compressed,
  output int error_count,
  output int check_count,
  output int pending
);

  // Entry is {full compare, instruction word, expected row}
  logic [90:0] expect_q [$];
  logic [90:0] head;
  // Every field except the illegal and compressed flags
  logic [55:0] payload;
  logic [57:0] actual;
  // instr_valid from one cycle back
  logic valid_d;

  assign payload = {dec_unit, dec_op, dec_rd_we, dec_rd, dec_rs1, dec_rs2, dec_use_imm, dec_imm};
  assign actual = {dec_illegal, payload, dec_compressed};

  ////////////////////////////////////////
  // Sampling on the falling edge
  ////////////////////////////////////////

  // Inputs change just after the rising edge and outputs settle on it,
  // so the falling edge sees both stable
  always @(negedge clk) begin
    if (rst) begin
      expect_q.delete();
      valid_d = 1'b0;
    end else begin
      // An illegal or idle output carries nothing but its flags
      if ((dec_illegal || !dec_valid) && payload != '0) begin
        error_count++;
        $display("[ERROR] %0t: fields %h not zero with dec_illegal=%0b dec_valid=%0b",
                 $time, payload, dec_illegal, dec_valid);
      end
      if (!dec_valid && (!dec_illegal || dec_compressed)) begin
        error_count++;
        $display("[ERROR] %0t: outputs not at the idle value while dec_valid is low", $time);
      end
      // Exactly one cycle from instr_valid to dec_valid
      if (dec_valid != valid_d) begin
        error_count++;
        $display("[ERROR] %0t: dec_valid=%0b, expected %0b from the previous cycle",
                 $time, dec_valid, valid_d);
      end
      if (dec_valid) begin
        if (expect_q.size() == 0) begin
          error_count++;
          $display("A result came out at %0t with no instruction waiting for it", $time);
        end else begin
          head = expect_q.pop_front();
          check_count++;
          // Random words only get the idle rule and the timing check
          if (head[90] && actual != head[57:0]) begin
            error_count++;
            $display("[ERROR] %0t: word %h gave %h, expected %h",
                     $time, head[89:58], actual, head[57:0]);
          end
        end
      end
      valid_d = instr_valid;
      if (instr_valid) begin
        expect_q.push_back({exp_full, instr_rdata, exp_row});
      end
    end
    pending = expect_q.size();
  end

endmodule

`default_nettype wire

/* verif/decode_tb.sv */
/*
  Decode stage testbench with clock, reset, the stimulus table
  applied back to back, a random pass and the closing verdict
*/
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decode_tb;

  localparam int DRAIN_LIMIT = 50;
  localparam int RANDOM_WORDS = 60;

  logic clk;
  logic rst;
  logic instr_valid;
  logic [`DEC_XLEN-1:0] instr_rdata;
  logic exp_full;
  logic [57:0] exp_row;
  logic dec_valid;
  logic dec_illegal;
  logic [2:0] dec_unit;
  logic [3:0] dec_op;
  logic dec_rd_we;
  logic [`DEC_REG_AW-1:0] dec_rd;
  logic [`DEC_REG_AW-1:0] dec_rs1;
  logic [`DEC_REG_AW-1:0] dec_rs2;
  logic dec_use_imm;
  logic [`DEC_XLEN-1:0] dec_imm;
  logic dec_compressed;
  int error_count;
  int check_count;
  int pending;

  // Stimulus table, one instruction word and one expected row per entry
  logic [`DEC_XLEN-1:0] words [$];
  logic [57:0] rows [$];
  integer seed;
  logic [31:0] rnd;
  logic [31:0] rnd_word;
  int wait_cycles;
  logic timed_out;

  decode_stage dut (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_rdata(instr_rdata),
    .dec_valid(dec_valid), .dec_illegal(dec_illegal), .dec_unit(dec_unit),
    .dec_op(dec_op), .dec_rd_we(dec_rd_we), .dec_rd(dec_rd), .dec_rs1(dec_rs1),
    .dec_rs2(dec_rs2), .dec_use_imm(dec_use_imm), .dec_imm(dec_imm),
    .dec_compressed(dec_compressed)
  );

  decode_checker u_checker (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_rdata(instr_rdata),
    .exp_full(exp_full), .exp_row(exp_row), .dec_valid(dec_valid),
    .dec_illegal(dec_illegal), .dec_unit(dec_unit), .dec_op(dec_op),
    .dec_rd_we(dec_rd_we), .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_compressed(dec_compressed),
    .error_count(error_count), .check_count(check_count), .pending(pending)
  );

  // Row fields in order are illegal, unit, op, rd_we, rd, rs1, rs2, use_imm, imm, compressed
  task automatic add_row(input logic [31:0] word, input int ill, input int unit, input int op,
                         input int we, input int rd, input int rs1, input int rs2,
                         input int ui, input int imm, input int comp);
    words.push_back(word);
    rows.push_back({ill[0], unit[2:0], op[3:0], we[0], rd[4:0], rs1[4:0], rs2[4:0],
                    ui[0], imm[31:0], comp[0]});
  endtask

  // Illegal words carry only their flags
  task automatic add_illegal(input logic [31:0] word, input int comp);
    add_row(word, 1, 0, 0, 0, 0, 0, 0, 0, 0, comp);
  endtask

  // Units are ALU 1, LSU 2, MULDIV 3, ATOMIC 4
  task automatic build_table();
    // add x3,x1,x2; sub x5,x6,x7; sra x10,x11,x12; slli x4,x9,13
    add_row(32'h002081B3, 0, 1, 0, 1, 3, 1, 2, 0, 0, 0);
    add_row(32'h407302B3, 0, 1, 1, 1, 5, 6, 7, 0, 0, 0);
    add_row(32'h40C5D533, 0, 1, 7, 1, 10, 11, 12, 0, 0, 0);
    add_row(32'h00D49213, 0, 1, 2, 1, 4, 9, 0, 1, 13, 0);
    // addi x8,x2,-5; lui x7,0xabcde; lw x14,-16(x15); sw x20,36(x21)
    add_row(32'hFFB10413, 0, 1, 0, 1, 8, 2, 0, 1, 32'hFFFFFFFB, 0);
    add_row(32'hABCDE3B7, 0, 1, 10, 1, 7, 0, 0, 1, 32'hABCDE000, 0);
    add_row(32'hFF07A703, 0, 2, 0, 1, 14, 15, 0, 1, 32'hFFFFFFF0, 0);
    add_row(32'h034AA223, 0, 2, 1, 0, 0, 21, 20, 1, 36, 0);
    // mul through remu on x1 = x2 op x3, op code equals funct3
    add_row(32'h023100B3, 0, 3, 0, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023110B3, 0, 3, 1, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023120B3, 0, 3, 2, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023130B3, 0, 3, 3, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023140B3, 0, 3, 4, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023150B3, 0, 3, 5, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023160B3, 0, 3, 6, 1, 1, 2, 3, 0, 0, 0);
    add_row(32'h023170B3, 0, 3, 7, 1, 1, 2, 3, 0, 0, 0);
    // lr.w, sc.w, amoswap.w, amoadd.w with aq set, amomax.w
    add_row(32'h100322AF, 0, 4, 0, 1, 5, 6, 0, 0, 0, 0);
    add_row(32'h1884A3AF, 0, 4, 1, 1, 7, 9, 8, 0, 0, 0);
    add_row(32'h08B6252F, 0, 4, 2, 1, 10, 12, 11, 0, 0, 0);
    add_row(32'h0421A0AF, 0, 4, 3, 1, 1, 3, 2, 0, 0, 0);
    add_row(32'hA0E7A6AF, 0, 4, 8, 1, 13, 15, 14, 0, 0, 0);
    // amominu.w is not supported, and lr.w must have rs2 at x0
    add_illegal(32'hC021A0AF, 0);
    add_illegal(32'h101322AF, 0);
    // c.addi x9,-3; c.li x10,7 with junk in the upper half; c.lui x11
    add_row(32'h000014F5, 0, 1, 0, 1, 9, 9, 0, 1, 32'hFFFFFFFD, 1);
    add_row(32'hDEAD451D, 0, 1, 0, 1, 10, 0, 0, 1, 7, 1);
    add_row(32'h00007585, 0, 1, 10, 1, 11, 0, 0, 1, 32'hFFFE1000, 1);
    // c.mv x12,x13; c.add x14,x15; c.lw x9,20(x10); c.sw x11,64(x8)
    add_row(32'h00008636, 0, 1, 0, 1, 12, 0, 13, 0, 0, 1);
    add_row(32'h0000973E, 0, 1, 0, 1, 14, 14, 15, 0, 0, 1);
    add_row(32'h00004944, 0, 2, 0, 1, 9, 10, 0, 1, 20, 1);
    add_row(32'h0000C02C, 0, 2, 1, 0, 0, 8, 11, 1, 64, 1);
    // c.j and c.jr are outside the supported set
    add_illegal(32'h0000A001, 1);
    add_illegal(32'h00008082, 1);
    // beq, ecall and fence all fall outside this stage
    add_illegal(32'h00208063, 0);
    add_illegal(32'h00000073, 0);
    add_illegal(32'h0FF0000F, 0);
  endtask

  // One cycle of stimulus, 2 ns after the rising edge
  task automatic drive(input logic valid, input logic [31:0] word, input logic full,
                       input logic [57:0] row);
    @(posedge clk);
    #2;
    instr_valid = valid;
    instr_rdata = word;
    exp_full = full;
    exp_row = row;
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed = 32'hb05ba835;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr_rdata = '0;
    exp_full = 1'b0;
    exp_row = '0;
    timed_out = 1'b0;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    // Idle cycles right after reset
    repeat (3) drive(1'b0, '0, 1'b0, '0);
    // The whole table back to back, one word per cycle
    for (int k = 0; k < words.size(); k++) begin
      drive(1'b1, words[k], 1'b1, rows[k]);
    end
    repeat (2) drive(1'b0, '0, 1'b0, '0);
    // Random words with random gaps, valid about three cycles in four
    for (int k = 0; k < RANDOM_WORDS; k++) begin
      rnd = $random(seed);
      rnd_word = $random(seed);
      drive(rnd[0] | rnd[1], rnd_word, 1'b0, '0);
    end
    drive(1'b0, '0, 1'b0, '0);
    wait_cycles = 0;
    while (pending != 0 && wait_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      wait_cycles++;
    end
    timed_out = (pending != 0);
    // A couple of idle cycles so the checker sees the stage at rest
    repeat (2) @(posedge clk);
    if (timed_out) begin
      $display("Timed out after %0d cycles with %0d results never seen", wait_cycles, pending);
    end
    $display("Rows: %0d  checks: %0d  errors: %0d", words.size(), check_count, error_count);
    if (error_count == 0 && !timed_out && check_count != 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
source/decode_pkg.sv
source/instr_fetch_if.sv
source/compressed_expander.sv
source/decoder_i.sv
source/decoder_m.sv
source/decoder_a.sv
source/instr_decoder.sv
source/decode_stage.sv
verif/decode_checker.sv
verif/decode_tb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the pass line appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
